/* rtl/scd_host_pkg.sv */
package scd_host_pkg;

	//////////////////////////////////////////
	// host download bus
	//////////////////////////////////////////
	localparam int HOST_ADDR_W = 25;
	localparam int HOST_DATA_W = 16;
	localparam int HOST_IDX_W  = 8;

	// only the low six index bits select the image type
	localparam int IDX_SEL_W = 6;

	localparam logic [IDX_SEL_W-1:0] IDX_CART_MAX = 6'h01;
	localparam logic [IDX_SEL_W-1:0] IDX_CDC_DAT  = 6'h02;
	localparam logic [IDX_SEL_W-1:0] IDX_CDC_SUB  = 6'h03;

	// region letter inside the cartridge header
	localparam logic [HOST_ADDR_W-1:0] HDR_ADDR  = 25'h00001F0;
	localparam logic [7:0]             CHR_JAPAN = "J";
	localparam logic [7:0]             CHR_USA   = "U";

	//////////////////////////////////////////
	// keyboard
	//////////////////////////////////////////
	localparam int KEY_CODE_W = 9;

	// enter and escape match on the low byte, extended prefix ignored
	localparam logic [7:0]            KEY_ENTER = 8'h5A;
	localparam logic [7:0]            KEY_ESC   = 8'h76;
	localparam logic [KEY_CODE_W-1:0] KEY_F1    = 9'h005;
	localparam logic [KEY_CODE_W-1:0] KEY_F2    = 9'h006;
	localparam logic [KEY_CODE_W-1:0] KEY_F3    = 9'h004;

	// console region codes
	localparam int REGION_W = 2;
	localparam logic [REGION_W-1:0] REGION_JP = 2'd0;
	localparam logic [REGION_W-1:0] REGION_US = 2'd1;
	localparam logic [REGION_W-1:0] REGION_EU = 2'd2;

	// drive link words
	localparam int CDD_WORD_W = 40;
	localparam int CD_LINK_W  = 49;
	localparam int CD_DM_BIT  = 40;
	localparam int CD_TGL_BIT = 48;

endpackage

/* rtl/host_dl_if.sv */
`timescale 1ns/1ps

// host download bus as seen by the watchers
interface host_dl_if
	import scd_host_pkg::*;
;

	logic                   download;
	logic [HOST_IDX_W-1:0]  index;
	logic                   wr;
	logic [HOST_ADDR_W-1:0] addr;
	logic [HOST_DATA_W-1:0] data;

	// passive view, nothing here drives the bus
	modport monitor (
		input download,
		input index,
		input wr,
		input addr,
		input data
	);

endinterface

/* rtl/key_event_decoder.sv */
`timescale 1ns/1ps

module key_event_decoder
	import scd_host_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  ps2_strobe,
	input  logic                  ps2_pressed,
	input  logic [KEY_CODE_W-1:0] ps2_code,
	output logic                  dbg_menu,
	output logic                  hot_valid,
	output logic [REGION_W-1:0]   hot_region,
	output logic                  hot_pressed
);

	logic strobe_q;
	logic strobe_chg;
	logic enter_q;
	logic esc_q;
	logic hot_hit;

	// every new key event toggles the strobe
	assign strobe_chg = ps2_strobe ^ strobe_q;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			strobe_q <= 1'b0;
			enter_q  <= 1'b0;
			esc_q    <= 1'b0;
			dbg_menu <= 1'b0;
		end else begin
			strobe_q <= ps2_strobe;
			if (strobe_chg) begin
				if (ps2_code[7:0] == KEY_ENTER)
					enter_q <= ps2_pressed;
				if (ps2_code[7:0] == KEY_ESC)
					esc_q <= ps2_pressed;
			end
			// enter+esc held together, clear wins over a new event
			if (enter_q & esc_q) begin
				dbg_menu <= ~dbg_menu;
				enter_q  <= 1'b0;
				esc_q    <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// region hotkeys
	////////////////////////////////////////
	always_comb begin
		hot_hit = 1'b1;
		case (ps2_code)
			KEY_F1: hot_region = REGION_JP;
			KEY_F2: hot_region = REGION_US;
			KEY_F3: hot_region = REGION_EU;
			default: begin
				hot_region = REGION_JP;
				hot_hit    = 1'b0;
			end
		endcase
	end

	assign hot_valid   = strobe_chg & hot_hit;
	assign hot_pressed = ps2_pressed;

endmodule

/* rtl/cart_header_sniff.sv */
`timescale 1ns/1ps

module cart_header_sniff
	import scd_host_pkg::*;
(
	input  logic            clk_sys,
	input  logic            rst,
	host_dl_if.monitor      dl,
	output logic            cart_loading,
	output logic            hdr_ready,
	output logic            hdr_j,
	output logic            hdr_u
);

	logic loading_q;

	// index 0 and 1 are both cartridge images
	assign cart_loading = dl.download & (dl.index[IDX_SEL_W-1:0] <= IDX_CART_MAX);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			loading_q <= 1'b0;
			hdr_ready <= 1'b0;
			hdr_j     <= 1'b0;
			hdr_u     <= 1'b0;
		end else begin
			loading_q <= cart_loading;
			// fresh download forgets the old letter
			if (!loading_q && cart_loading) begin
				hdr_ready <= 1'b0;
				hdr_j     <= 1'b0;
				hdr_u     <= 1'b0;
			end
			if (loading_q && !cart_loading)
				hdr_ready <= 1'b0;
			// header write overrides the edge clears
			if (dl.wr && cart_loading && dl.addr == HDR_ADDR) begin
				if (dl.data[7:0] == CHR_JAPAN)
					hdr_j <= 1'b1;
				else if (dl.data[7:0] == CHR_USA)
					hdr_u <= 1'b1;
				hdr_ready <= 1'b1;
			end
		end
	end

endmodule

/* rtl/region_config.sv */
`timescale 1ns/1ps

module region_config
	import scd_host_pkg::*;
(
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                hot_valid,
	input  logic [REGION_W-1:0] hot_region,
	input  logic                hot_pressed,
	input  logic                hdr_ready,
	input  logic                hdr_j,
	input  logic                hdr_u,
	output logic [REGION_W-1:0] region_req,
	output logic                region_set
);

	logic ready_q;
	logic ready_rise;
	logic ready_fall;

	assign ready_rise = ~ready_q & hdr_ready;
	assign ready_fall = ready_q & ~hdr_ready;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ready_q    <= 1'b0;
			region_req <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr_ready;

			// hotkey, header below overrides in the same cycle
			if (hot_valid) begin
				region_req <= hot_region;
				region_set <= hot_pressed;
			end

			// header letter, US before JP, EU otherwise
			if (ready_rise) begin
				region_set <= 1'b1;
				if (hdr_u)
					region_req <= REGION_US;
				else if (hdr_j)
					region_req <= REGION_JP;
				else
					region_req <= REGION_EU;
			end

			if (ready_fall)
				region_set <= 1'b0;
		end
	end

endmodule

/* rtl/cdc_feed.sv */
`timescale 1ns/1ps

module cdc_feed
	import scd_host_pkg::*;
#(
	parameter int CDC_HOLD_CYCLES = 8
) (
	input  logic                   clk_sys,
	input  logic                   rst,
	host_dl_if.monitor             dl,
	output logic [HOST_DATA_W-1:0] cdc_data,
	output logic                   cdc_dat_wr,
	output logic                   cdc_sc_wr
);

	localparam int CNT_W = $clog2(CDC_HOLD_CYCLES);

	logic [CNT_W-1:0] cnt;
	logic             hold;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cnt  <= '0;
			hold <= 1'b0;
		end else if (dl.wr) begin
			// restart the stretch on every write
			cnt  <= CNT_W'(CDC_HOLD_CYCLES - 1);
			hold <= 1'b1;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end else begin
			hold <= 1'b0;
		end
	end

	// last host word
	always_ff @(posedge clk_sys) begin
		if (dl.wr)
			cdc_data <= dl.data;
	end

	// steer by the live index
	assign cdc_dat_wr = hold & dl.download & (dl.index[IDX_SEL_W-1:0] == IDX_CDC_DAT);
	assign cdc_sc_wr  = hold & dl.download & (dl.index[IDX_SEL_W-1:0] == IDX_CDC_SUB);

endmodule

/* rtl/cdd_link.sv */
`timescale 1ns/1ps

module cdd_link
	import scd_host_pkg::*;
#(
	parameter int REC_HOLD_CYCLES = 8
) (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic [CD_LINK_W-1:0]  cd_out,
	input  logic                  cdd_send,
	input  logic [CDD_WORD_W-1:0] cdd_comm,
	output logic [CD_LINK_W-1:0]  cd_in,
	output logic [CDD_WORD_W-1:0] cdd_stat,
	output logic                  cdd_dm,
	output logic                  cdd_rec
);

	localparam int CNT_W = $clog2(REC_HOLD_CYCLES);

	logic             tgl_last;
	logic             tgl_chg;
	logic [CNT_W-1:0] cnt;
	logic             send_q;

	assign tgl_chg = cd_out[CD_TGL_BIT] != tgl_last;

	////////////////////////////////////////
	// drive to controller
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			// drive side idles with its toggle at 1
			tgl_last <= 1'b1;
			cnt      <= '0;
			cdd_rec  <= 1'b0;
		end else if (tgl_chg) begin
			tgl_last <= cd_out[CD_TGL_BIT];
			cnt      <= CNT_W'(REC_HOLD_CYCLES - 1);
			cdd_rec  <= 1'b1;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end else begin
			cdd_rec <= 1'b0;
		end
	end

	// status word and dm flag ride with the toggle
	always_ff @(posedge clk_sys) begin
		if (tgl_chg) begin
			cdd_stat <= cd_out[CDD_WORD_W-1:0];
			cdd_dm   <= cd_out[CD_DM_BIT];
		end
	end

	////////////////////////////////////////
	// controller to drive
	////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			send_q <= 1'b0;
			cd_in  <= '0;
		end else begin
			send_q <= cdd_send;
			if (cdd_send && !send_q)
				cd_in <= {~cd_in[CD_TGL_BIT], 8'h00, cdd_comm};
		end
	end

endmodule

/* rtl/scd_host_top.sv */
`timescale 1ns/1ps

module scd_host_top
	import scd_host_pkg::*;
#(
	parameter int CDC_HOLD_CYCLES = 8,
	parameter int REC_HOLD_CYCLES = 8
) (
	input  logic                   clk_sys,
	input  logic                   rst,

	input  logic                   ps2_strobe,
	input  logic                   ps2_pressed,
	input  logic [KEY_CODE_W-1:0]  ps2_code,

	input  logic                   host_download,
	input  logic [HOST_IDX_W-1:0]  host_index,
	input  logic                   host_wr,
	input  logic [HOST_ADDR_W-1:0] host_addr,
	input  logic [HOST_DATA_W-1:0] host_data,

	input  logic [CD_LINK_W-1:0]   cd_out,
	input  logic                   cdd_send,
	input  logic [CDD_WORD_W-1:0]  cdd_comm,

	output logic [CD_LINK_W-1:0]   cd_in,
	output logic [CDD_WORD_W-1:0]  cdd_stat,
	output logic                   cdd_dm,
	output logic                   cdd_rec,
	output logic [HOST_DATA_W-1:0] cdc_data,
	output logic                   cdc_dat_wr,
	output logic                   cdc_sc_wr,
	output logic [REGION_W-1:0]    region_req,
	output logic                   region_set,
	output logic                   dbg_menu,
	output logic                   cart_loading
);

	logic                hot_valid;
	logic [REGION_W-1:0] hot_region;
	logic                hot_pressed;
	logic                hdr_ready;
	logic                hdr_j;
	logic                hdr_u;

	host_dl_if dl ();

	assign dl.download = host_download;
	assign dl.index    = host_index;
	assign dl.wr       = host_wr;
	assign dl.addr     = host_addr;
	assign dl.data     = host_data;

	////////////////////////////////////////
	// keyboard and region
	////////////////////////////////////////
	key_event_decoder u_key_event_decoder (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.ps2_strobe  (ps2_strobe),
		.ps2_pressed (ps2_pressed),
		.ps2_code    (ps2_code),
		.dbg_menu    (dbg_menu),
		.hot_valid   (hot_valid),
		.hot_region  (hot_region),
		.hot_pressed (hot_pressed)
	);

	cart_header_sniff u_cart_header_sniff (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.dl           (dl.monitor),
		.cart_loading (cart_loading),
		.hdr_ready    (hdr_ready),
		.hdr_j        (hdr_j),
		.hdr_u        (hdr_u)
	);

	region_config u_region_config (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.hot_valid   (hot_valid),
		.hot_region  (hot_region),
		.hot_pressed (hot_pressed),
		.hdr_ready   (hdr_ready),
		.hdr_j       (hdr_j),
		.hdr_u       (hdr_u),
		.region_req  (region_req),
		.region_set  (region_set)
	);

	////////////////////////////////////////
	// disc feed and drive link
	////////////////////////////////////////
	cdc_feed #(
		.CDC_HOLD_CYCLES (CDC_HOLD_CYCLES)
	) u_cdc_feed (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.dl         (dl.monitor),
		.cdc_data   (cdc_data),
		.cdc_dat_wr (cdc_dat_wr),
		.cdc_sc_wr  (cdc_sc_wr)
	);

	cdd_link #(
		.REC_HOLD_CYCLES (REC_HOLD_CYCLES)
	) u_cdd_link (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.cd_out   (cd_out),
		.cdd_send (cdd_send),
		.cdd_comm (cdd_comm),
		.cd_in    (cd_in),
		.cdd_stat (cdd_stat),
		.cdd_dm   (cdd_dm),
		.cdd_rec  (cdd_rec)
	);

endmodule

/* sim/scd_host_sva.sv */
`timescale 1ns/1ps

module scd_host_sva
	import scd_host_pkg::*;
#(
	parameter int REC_HOLD_CYCLES = 8
) (
	input logic                 clk_sys,
	input logic                 rst,
	input logic [CD_LINK_W-1:0] cd_out,
	input logic [CD_LINK_W-1:0] cd_in,
	input logic                 cdd_send,
	input logic                 cdd_rec,
	input logic                 cdc_dat_wr,
	input logic                 cdc_sc_wr
);

	logic tgl_seen;
	int   rec_left;
	int   assert_errors = 0;

	// receive window tracker restarted on every toggle change
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			tgl_seen <= 1'b1;
			rec_left <= 0;
		end else if (cd_out[CD_TGL_BIT] != tgl_seen) begin
			tgl_seen <= cd_out[CD_TGL_BIT];
			rec_left <= REC_HOLD_CYCLES;
		end else if (rec_left != 0) begin
			rec_left <= rec_left - 1;
		end
	end

	rec_hold_len: assert property (@(posedge clk_sys) disable iff (rst)
		cdd_rec == (rec_left != 0))
		else begin
			assert_errors++;
			$error("cdd_rec window length wrong");
		end

	feed_onehot: assert property (@(posedge clk_sys) disable iff (rst)
		!(cdc_dat_wr && cdc_sc_wr))
		else begin
			assert_errors++;
			$error("data and subcode strobes high together");
		end

	// toggle moves only right after a rising send
	send_toggle: assert property (@(posedge clk_sys) disable iff (rst)
		(cd_in[CD_TGL_BIT] != $past(cd_in[CD_TGL_BIT]))
		|-> ($past(cdd_send) && !$past(cdd_send, 2)))
		else begin
			assert_errors++;
			$error("cd_in toggle moved without a send edge");
		end

endmodule

bind scd_host_top scd_host_sva #(
	.REC_HOLD_CYCLES (REC_HOLD_CYCLES)
) u_scd_host_sva (
	.clk_sys    (clk_sys),
	.rst        (rst),
	.cd_out     (cd_out),
	.cd_in      (cd_in),
	.cdd_send   (cdd_send),
	.cdd_rec    (cdd_rec),
	.cdc_dat_wr (cdc_dat_wr),
	.cdc_sc_wr  (cdc_sc_wr)
);

/* sim/tb_scd_host.sv */
`timescale 1ns/1ps

module tb_scd_host
	import scd_host_pkg::*;
;

	localparam int CDC_HOLD = 8;
	localparam int REC_HOLD = 8;

	localparam int KEY_EVENTS  = 300;
	localparam int CART_LOADS  = 20;
	localparam int CART_WRITES = 30;
	localparam int CDC_LOADS   = 20;
	localparam int CDC_WRITES  = 20;
	localparam int TGL_EVENTS  = 60;
	localparam int SEND_EVENTS = 60;

	// worst case length of every phase plus slack
	localparam int MAX_CYCLES = 10 + KEY_EVENTS * 4
		+ CART_LOADS * (CART_WRITES * 4 + 12)
		+ CDC_LOADS * (CDC_WRITES * 14 + 18)
		+ TGL_EVENTS * 13 + SEND_EVENTS * 8 + 1000;

	logic                   clk_sys;
	logic                   rst;
	logic                   ps2_strobe;
	logic                   ps2_pressed;
	logic [KEY_CODE_W-1:0]  ps2_code;
	logic                   host_download;
	logic [HOST_IDX_W-1:0]  host_index;
	logic                   host_wr;
	logic [HOST_ADDR_W-1:0] host_addr;
	logic [HOST_DATA_W-1:0] host_data;
	logic [CD_LINK_W-1:0]   cd_out;
	logic                   cdd_send;
	logic [CDD_WORD_W-1:0]  cdd_comm;
	logic [CD_LINK_W-1:0]   cd_in;
	logic [CDD_WORD_W-1:0]  cdd_stat;
	logic                   cdd_dm;
	logic                   cdd_rec;
	logic [HOST_DATA_W-1:0] cdc_data;
	logic                   cdc_dat_wr;
	logic                   cdc_sc_wr;
	logic [REGION_W-1:0]    region_req;
	logic                   region_set;
	logic                   dbg_menu;
	logic                   cart_loading;

	logic [15:0] lfsr_state;
	int          cycle_count = 0;

	// model state
	logic                   m_strobe_q;
	logic                   m_enter;
	logic                   m_esc;
	logic                   m_dbg;
	logic                   m_load_q;
	logic                   m_rdy;
	logic                   m_rdy_q;
	logic                   m_j;
	logic                   m_u;
	logic [REGION_W-1:0]    m_req;
	logic                   m_set;
	int                     m_cdc_left;
	logic [HOST_DATA_W-1:0] m_cdc_data;
	logic                   m_cdc_seen;
	logic                   m_tgl_last;
	int                     m_rec_left;
	logic [CDD_WORD_W-1:0]  m_stat;
	logic                   m_dm;
	logic                   m_stat_seen;
	logic                   m_send_q;
	logic [CD_LINK_W-1:0]   m_cd_in;

	scd_host_top #(
		.CDC_HOLD_CYCLES (CDC_HOLD),
		.REC_HOLD_CYCLES (REC_HOLD)
	) u_scd_host_top (.*);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	//////////////////////////////////////////
	// random source
	//////////////////////////////////////////
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[62:0], lfsr_step()};
		return v;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [7:0] r;
		r = 8'(rand_bits(8));
		return lo + (int'(r) % (hi - lo + 1));
	endfunction

	// cartridge images use the low six index bits 0 and 1
	function automatic logic is_cart_load(input logic dl, input logic [HOST_IDX_W-1:0] idx);
		return dl && (idx[5:0] <= IDX_CART_MAX);
	endfunction

	task automatic value_error(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	//////////////////////////////////////////
	// reference model
	//////////////////////////////////////////
	always @(posedge clk_sys) begin : model_step
		logic                chg;
		logic                hv;
		logic [REGION_W-1:0] hot_reg;
		logic                rdy_rise;
		logic                rdy_fall;
		logic                load_now;
		if (rst) begin
			m_strobe_q  = 1'b0;
			m_enter     = 1'b0;
			m_esc       = 1'b0;
			m_dbg       = 1'b0;
			m_load_q    = 1'b0;
			m_rdy       = 1'b0;
			m_rdy_q     = 1'b0;
			m_j         = 1'b0;
			m_u         = 1'b0;
			m_req       = REGION_JP;
			m_set       = 1'b0;
			m_cdc_left  = 0;
			m_cdc_seen  = 1'b0;
			m_tgl_last  = 1'b1;
			m_rec_left  = 0;
			m_stat_seen = 1'b0;
			m_send_q    = 1'b0;
			m_cd_in     = '0;
		end else begin
			// keyboard
			chg = ps2_strobe ^ m_strobe_q;
			m_strobe_q = ps2_strobe;
			if (m_enter && m_esc) begin
				m_dbg   = ~m_dbg;
				m_enter = 1'b0;
				m_esc   = 1'b0;
			end else if (chg) begin
				if (ps2_code[7:0] == KEY_ENTER)
					m_enter = ps2_pressed;
				if (ps2_code[7:0] == KEY_ESC)
					m_esc = ps2_pressed;
			end
			hv = chg;
			hot_reg = REGION_JP;
			if (ps2_code == KEY_F2)
				hot_reg = REGION_US;
			else if (ps2_code == KEY_F3)
				hot_reg = REGION_EU;
			else if (ps2_code != KEY_F1)
				hv = 1'b0;

			// region register sees the header flags of the last cycle
			rdy_rise = m_rdy && !m_rdy_q;
			rdy_fall = !m_rdy && m_rdy_q;
			m_rdy_q = m_rdy;
			if (hv) begin
				m_req = hot_reg;
				m_set = ps2_pressed;
			end
			if (rdy_rise) begin
				m_set = 1'b1;
				m_req = m_u ? REGION_US : (m_j ? REGION_JP : REGION_EU);
			end
			if (rdy_fall)
				m_set = 1'b0;

			// header letter
			load_now = is_cart_load(host_download, host_index);
			if (load_now && !m_load_q) begin
				m_rdy = 1'b0;
				m_j   = 1'b0;
				m_u   = 1'b0;
			end
			if (!load_now && m_load_q)
				m_rdy = 1'b0;
			if (host_wr && load_now && host_addr == HDR_ADDR) begin
				m_rdy = 1'b1;
				if (host_data[7:0] == CHR_JAPAN)
					m_j = 1'b1;
				else if (host_data[7:0] == CHR_USA)
					m_u = 1'b1;
			end
			m_load_q = load_now;

			// disc feed
			if (host_wr) begin
				m_cdc_left = CDC_HOLD;
				m_cdc_data = host_data;
				m_cdc_seen = 1'b1;
			end else if (m_cdc_left > 0) begin
				m_cdc_left--;
			end

			// drive link
			if (cd_out[CD_TGL_BIT] != m_tgl_last) begin
				m_tgl_last  = cd_out[CD_TGL_BIT];
				m_rec_left  = REC_HOLD;
				m_stat      = cd_out[CDD_WORD_W-1:0];
				m_dm        = cd_out[CD_DM_BIT];
				m_stat_seen = 1'b1;
			end else if (m_rec_left > 0) begin
				m_rec_left--;
			end
			if (cdd_send && !m_send_q)
				m_cd_in = {~m_cd_in[CD_TGL_BIT], 8'h00, cdd_comm};
			m_send_q = cdd_send;
		end
	end

	// outputs settle well before the falling edge
	always @(negedge clk_sys) begin
		if (!rst) begin
			assert (dbg_menu == m_dbg)
				else value_error($sformatf("dbg_menu %0b, expected %0b", dbg_menu, m_dbg));
			assert (region_req == m_req)
				else value_error($sformatf("region_req %0d, expected %0d", region_req, m_req));
			assert (region_set == m_set)
				else value_error($sformatf("region_set %0b, expected %0b", region_set, m_set));
			assert (cart_loading == is_cart_load(host_download, host_index))
				else value_error("cart_loading does not follow the index rule");
			assert (cdc_dat_wr == (m_cdc_left != 0 && host_download
				&& host_index[5:0] == IDX_CDC_DAT))
				else value_error($sformatf("cdc_dat_wr %0b unexpected", cdc_dat_wr));
			assert (cdc_sc_wr == (m_cdc_left != 0 && host_download
				&& host_index[5:0] == IDX_CDC_SUB))
				else value_error($sformatf("cdc_sc_wr %0b unexpected", cdc_sc_wr));
			if (m_cdc_seen)
				assert (cdc_data == m_cdc_data)
					else value_error($sformatf("cdc_data %h, expected %h", cdc_data, m_cdc_data));
			assert (cdd_rec == (m_rec_left != 0))
				else value_error($sformatf("cdd_rec %0b unexpected", cdd_rec));
			if (m_stat_seen) begin
				assert (cdd_stat == m_stat && cdd_dm == m_dm)
					else value_error($sformatf("cdd_stat %h dm %0b, expected %h dm %0b",
						cdd_stat, cdd_dm, m_stat, m_dm));
			end
			assert (cd_in == m_cd_in)
				else value_error($sformatf("cd_in %h, expected %h", cd_in, m_cd_in));
		end
	end

	//////////////////////////////////////////
	// stimulus phases
	//////////////////////////////////////////
	task automatic key_phase();
		logic [2:0] pick;
		for (int i = 0; i < KEY_EVENTS; i++) begin
			pick = 3'(rand_bits(3));
			@(posedge clk_sys);
			// enter and escape twice as often so that pairs happen
			case (pick)
				3'd0, 3'd1: ps2_code <= {1'b0, KEY_ENTER};
				3'd2, 3'd3: ps2_code <= {1'b0, KEY_ESC};
				3'd4: ps2_code <= KEY_F1;
				3'd5: ps2_code <= KEY_F2;
				3'd6: ps2_code <= KEY_F3;
				default: ps2_code <= 9'(rand_bits(9));
			endcase
			ps2_pressed <= (2'(rand_bits(2)) != 2'd0);
			ps2_strobe  <= ~ps2_strobe;
			idle(rand_range(0, 2));
		end
	endtask

	task automatic cart_phase();
		int         hdr_at;
		logic [1:0] sel;
		logic [7:0] letter;
		for (int l = 0; l < CART_LOADS; l++) begin
			hdr_at = rand_range(0, CART_WRITES - 1);
			@(posedge clk_sys);
			host_download <= 1'b1;
			host_index    <= {2'(rand_bits(2)), 5'd0, 1'(rand_bits(1))};
			for (int w = 0; w < CART_WRITES; w++) begin
				sel = 2'(rand_bits(2));
				letter = (sel == 2'd0) ? CHR_JAPAN : (sel == 2'd1) ? CHR_USA : 8'(rand_bits(8));
				@(posedge clk_sys);
				host_wr <= 1'b1;
				if (w == hdr_at) begin
					host_addr <= HDR_ADDR;
					host_data <= {8'(rand_bits(8)), letter};
				end else begin
					host_addr <= 25'(rand_bits(12));
					host_data <= 16'(rand_bits(16));
				end
				@(posedge clk_sys);
				host_wr <= 1'b0;
				idle(rand_range(0, 2));
			end
			@(posedge clk_sys);
			host_download <= 1'b0;
			idle(rand_range(4, 8));
		end
	endtask

	task automatic cdc_phase();
		logic [1:0] sel;
		for (int l = 0; l < CDC_LOADS; l++) begin
			sel = 2'(rand_bits(2));
			@(posedge clk_sys);
			host_download <= 1'b1;
			case (sel)
				2'd0: host_index <= {2'(rand_bits(2)), IDX_CDC_DAT};
				2'd1: host_index <= {2'(rand_bits(2)), IDX_CDC_SUB};
				default: host_index <= 8'h05;
			endcase
			for (int w = 0; w < CDC_WRITES; w++) begin
				@(posedge clk_sys);
				host_wr   <= 1'b1;
				host_addr <= 25'(rand_bits(20));
				host_data <= 16'(rand_bits(16));
				@(posedge clk_sys);
				host_wr <= 1'b0;
				idle(rand_range(0, 12));
			end
			@(posedge clk_sys);
			host_download <= 1'b0;
			idle(rand_range(4, 12));
		end
	endtask

	task automatic tgl_phase();
		for (int i = 0; i < TGL_EVENTS; i++) begin
			@(posedge clk_sys);
			cd_out <= {~cd_out[CD_TGL_BIT], 8'(rand_bits(8)), 40'(rand_bits(40))};
			idle(rand_range(0, 11));
		end
	endtask

	task automatic send_phase();
		for (int i = 0; i < SEND_EVENTS; i++) begin
			@(posedge clk_sys);
			cdd_send <= 1'b1;
			cdd_comm <= 40'(rand_bits(40));
			idle(rand_range(0, 2));
			@(posedge clk_sys);
			cdd_send <= 1'b0;
			idle(rand_range(0, 3));
		end
	endtask

	//////////////////////////////////////////
	// run control
	//////////////////////////////////////////
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end

	initial begin
		lfsr_state    = 16'd14;
		rst           = 1'b1;
		ps2_strobe    = 1'b0;
		ps2_pressed   = 1'b0;
		ps2_code      = '0;
		host_download = 1'b0;
		host_index    = '0;
		host_wr       = 1'b0;
		host_addr     = '0;
		host_data     = '0;
		// drive toggle idles at 1
		cd_out        = {1'b1, 48'h0};
		cdd_send      = 1'b0;
		cdd_comm      = '0;
		repeat (10) @(posedge clk_sys);
		rst <= 1'b0;
		key_phase();
		cart_phase();
		cdc_phase();
		tgl_phase();
		send_phase();
		idle(20);
		// protocol checker failures are counted inside the bound module
		if (u_scd_host_top.u_scd_host_sva.assert_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* filelist.f */
rtl/scd_host_pkg.sv
rtl/host_dl_if.sv
rtl/key_event_decoder.sv
rtl/cart_header_sniff.sv
rtl/region_config.sv
rtl/cdc_feed.sv
rtl/cdd_link.sv
rtl/scd_host_top.sv
sim/scd_host_sva.sv
sim/tb_scd_host.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_scd_host \
	-f filelist.f \
	--Mdir obj_dir \
	-o tb_scd_host

./obj_dir/tb_scd_host > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	exit 1
fi
exit 0
